//--- src/scan_pkg.sv
package scan_pkg;

	// One GMII octet
	typedef logic [7:0] octet_t;
	// Octet offset inside a frame, also the frame length
	typedef logic [10:0] frame_cnt_t;
	// IP and UDP length fields
	typedef logic [15:0] len16_t;
	// Configuration memory address
	typedef logic [3:0] cfg_addr_t;

	// Codes 1 and 2 stay reserved for ARP and ICMP
	typedef enum logic [1:0] {
		cat_other = 2'd0,
		cat_udp   = 2'd3
	} category_t;

	typedef enum logic [1:0] {
		st_idle     = 2'd0,
		st_preamble = 2'd1,
		st_data     = 2'd2,
		st_drop     = 2'd3
	} framer_state_t;

	typedef struct packed {
		octet_t data;
		logic   valid;
		logic   last;
	} rx_octet_t;

	typedef struct packed {
		category_t  category;
		logic       crc_ok;
		logic       mac_ok;
		logic       ip_ok;
		frame_cnt_t pack_len;
	} scan_status_t;

	// Offsets counted from the first octet after the delimiter
	localparam frame_cnt_t off_ethertype = 11'd12;
	localparam frame_cnt_t off_ip_len = 11'd16;
	localparam frame_cnt_t off_ttl = 11'd22;
	localparam frame_cnt_t off_proto = 11'd23;
	localparam frame_cnt_t off_ip_dst = 11'd30;
	localparam frame_cnt_t off_udp_src = 11'd34;
	localparam frame_cnt_t off_udp_dst = 11'd36;
	localparam frame_cnt_t off_udp_len = 11'd38;

	// Six MAC octets, then four IP octets
	localparam cfg_addr_t cfg_mac_base = 4'd0;
	localparam cfg_addr_t cfg_ip_base = 4'd6;

endpackage

//--- src/rx_framer.sv
`timescale 1ns/1ps

module rx_framer
	import scan_pkg::*;
#(
	parameter int max_frame_len = 1536,
	parameter int min_ifg = 10
) (
	input  logic       clk,
	input  logic       arst_n,
	input  rx_octet_t  rx,
	input  logic       enable_rx,
	output frame_cnt_t cnt,
	output octet_t     d1,
	output logic       in_data,
	output logic       frame_first,
	output logic       frame_end,
	output rx_octet_t  odata
);

	// Gap count saturates here
	localparam logic [3:0] gap_sat = 4'd12;

	framer_state_t state;
	logic en_meta;
	logic en_sync;
	logic [3:0] gap_cnt;
	logic ifg_ok;
	logic too_long;
	logic v1;
	logic v2;
	logic end_q;
	logic end_d;
	octet_t d2;
	octet_t out_data;
	logic out_valid;

	assign ifg_ok = int'(gap_cnt) >= min_ifg;
	assign too_long = int'(cnt) >= max_frame_len;
	assign in_data = state == st_data;

	// enable_rx comes from another clock domain
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			en_meta <= 1'b0;
			en_sync <= 1'b0;
		end else begin
			en_meta <= enable_rx;
			en_sync <= en_meta;
		end
	end

	// Quiet line after reset counts as a full gap
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gap_cnt <= gap_sat;
		end else if (state == st_idle) begin
			if (gap_cnt != gap_sat) begin
				gap_cnt <= gap_cnt + 4'd1;
			end
		end else if (state != st_preamble) begin
			gap_cnt <= '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (rx.valid) begin
						state <= (rx.data == 8'h55 && en_sync) ? st_preamble : st_drop;
					end
				end
				st_preamble: begin
					if (!rx.valid) begin
						state <= st_idle;
					end else if (rx.data == 8'hd5) begin
						// Delimiter after a short gap is refused
						state <= ifg_ok ? st_data : st_drop;
					end else if (rx.data != 8'h55) begin
						state <= st_drop;
					end
				end
				st_data: begin
					if (!rx.valid) begin
						state <= st_idle;
					end else if (too_long) begin
						state <= st_drop;
					end
				end
				default: begin
					// Drop waits for the end of the burst
					if (!rx.valid) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// Counter and strobes, one cycle behind the state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			frame_first <= 1'b0;
			v1 <= 1'b0;
			v2 <= 1'b0;
			out_valid <= 1'b0;
			end_q <= 1'b0;
			end_d <= 1'b0;
		end else begin
			cnt <= in_data ? cnt + 11'd1 : '0;
			frame_first <= in_data && cnt == '0;
			v1 <= in_data & rx.valid;
			v2 <= v1;
			out_valid <= v2;
			// Only a clean end of data counts, never a drop
			end_q <= in_data & ~rx.valid;
			end_d <= end_q;
		end
	end

	// Octet pipeline, idle octets squelched to zero
	always_ff @(posedge clk) begin
		d1 <= rx.valid ? rx.data : 8'h00;
		d2 <= d1;
		out_data <= d2;
	end

	assign frame_end = end_d;
	assign odata = '{data: out_data, valid: out_valid, last: end_d};

endmodule

//--- src/addr_match.sv
`timescale 1ns/1ps

module addr_match
	import scan_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  frame_cnt_t cnt,
	input  octet_t     d1,
	output cfg_addr_t  cfg_addr,
	input  octet_t     cfg_data,
	output logic       mac_ok,
	output logic       ip_dst_ok,
	output logic       src_unicast
);

	// Source MAC starts right after the six destination octets
	localparam frame_cnt_t mac_len = 11'd6;

	logic in_mac_win;
	logic in_ip_win;
	frame_cnt_t ip_ofs;
	logic want_mac;
	logic want_ip;
	logic entry_match;

	assign in_mac_win = cnt < mac_len;
	assign in_ip_win = cnt >= off_ip_dst && cnt < off_ip_dst + 11'd4;
	assign ip_ofs = cnt - off_ip_dst;

	// Address out now, memory answers next cycle
	always_comb begin
		if (in_ip_win) begin
			cfg_addr = cfg_ip_base + {2'b00, ip_ofs[1:0]};
		end else if (in_mac_win) begin
			cfg_addr = cfg_mac_base + cnt[3:0];
		end else begin
			cfg_addr = cfg_mac_base;
		end
	end

	// Memory data lines up with the octet in d1
	assign entry_match = cfg_data == d1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			want_mac <= 1'b0;
			want_ip <= 1'b0;
			mac_ok <= 1'b0;
			ip_dst_ok <= 1'b0;
			src_unicast <= 1'b0;
		end else begin
			want_mac <= in_mac_win;
			want_ip <= in_ip_win;
			if (want_mac && !entry_match) begin
				mac_ok <= 1'b0;
			end
			if (want_ip && !entry_match) begin
				ip_dst_ok <= 1'b0;
			end
			// Group bit of the source MAC
			if (cnt == mac_len + 11'd1) begin
				src_unicast <= ~d1[0];
			end
			// New frame starts optimistic
			if (cnt == '0) begin
				mac_ok <= 1'b1;
				ip_dst_ok <= 1'b1;
				src_unicast <= 1'b1;
			end
		end
	end

endmodule

//--- src/ip_hdr_check.sv
`timescale 1ns/1ps

module ip_hdr_check
	import scan_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  frame_cnt_t cnt,
	input  octet_t     d1,
	output logic       ip_hdr_ok,
	output len16_t     ip_length
);

	// Version and IHL octet, flags, end of the 20 octet header
	localparam frame_cnt_t off_ip_hdr = off_ethertype + 11'd2;
	localparam frame_cnt_t off_frag = off_ttl - 11'd2;
	localparam frame_cnt_t off_hdr_end = off_ip_dst + 11'd4;

	octet_t template_q;
	logic want;
	logic mask_df;
	logic ttl_slot;
	octet_t df_mask;
	logic tmpl_match;
	octet_t d1_q;
	logic cks_gate;
	logic cks_phase;
	octet_t cks_hi;
	logic [15:0] cks_sum;
	logic [16:0] cks_add;
	logic [15:0] cks_next;

	// Expected octet, ready when that octet reaches d1
	always_ff @(posedge clk) begin
		case (cnt)
			off_ethertype: template_q <= 8'h08;
			off_ethertype + 11'd1: template_q <= 8'h00;
			off_ip_hdr: template_q <= 8'h45;
			default: template_q <= 8'h00;
		endcase
	end

	// DF bit is free in the first flag octet
	assign df_mask = {1'b1, ~mask_df, 6'h3f};
	assign tmpl_match = (d1 & df_mask) == template_q;

	// End around carry keeps the sum in one's complement
	assign cks_add = {1'b0, cks_sum} + {1'b0, cks_hi, d1};
	assign cks_next = cks_add[15:0] + {15'b0, cks_add[16]};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			want <= 1'b0;
			mask_df <= 1'b0;
			ttl_slot <= 1'b0;
			cks_gate <= 1'b0;
			cks_phase <= 1'b0;
			cks_sum <= '0;
			ip_hdr_ok <= 1'b0;
		end else begin
			want <= (cnt >= off_ethertype && cnt <= off_ip_hdr) ||
				cnt == off_frag || cnt == off_frag + 11'd1;
			mask_df <= cnt == off_frag;
			ttl_slot <= cnt == off_ttl;
			cks_gate <= cnt >= off_ip_hdr && cnt < off_hdr_end;
			if (cks_gate) begin
				cks_phase <= ~cks_phase;
				// Add a word on its low octet
				if (cks_phase) begin
					cks_sum <= cks_next;
				end
			end
			if (want && !tmpl_match) begin
				ip_hdr_ok <= 1'b0;
			end
			// Expired packet
			if (ttl_slot && d1 == 8'h00) begin
				ip_hdr_ok <= 1'b0;
			end
			// Last header word is in the sum one cycle after the window
			if (cnt == off_hdr_end + 11'd1 && cks_sum != 16'hffff) begin
				ip_hdr_ok <= 1'b0;
			end
			if (cnt == '0) begin
				ip_hdr_ok <= 1'b1;
				cks_phase <= 1'b0;
				cks_sum <= '0;
			end
		end
	end

	// High octet of each word, and total length capture
	always_ff @(posedge clk) begin
		d1_q <= d1;
		if (cks_gate && !cks_phase) begin
			cks_hi <= d1;
		end
		if (cnt == off_ip_len + 11'd2) begin
			ip_length <= {d1_q, d1};
		end
	end

endmodule

//--- src/udp_hdr_check.sv
`timescale 1ns/1ps

module udp_hdr_check
	import scan_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  frame_cnt_t cnt,
	input  octet_t     d1,
	output logic       udp_ok,
	output len16_t     udp_length
);

	logic want_proto;
	logic dst_hi_zero;
	octet_t d1_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			want_proto <= 1'b0;
			dst_hi_zero <= 1'b0;
			udp_ok <= 1'b0;
		end else begin
			want_proto <= cnt == off_proto;
			if (want_proto && d1 != 8'h11) begin
				udp_ok <= 1'b0;
			end
			// Source port below 1024 has a high octet under 4
			if (cnt == off_udp_src + 11'd1 && d1[7:2] == 6'd0) begin
				udp_ok <= 1'b0;
			end
			if (cnt == off_udp_dst + 11'd1) begin
				dst_hi_zero <= d1 == 8'h00;
			end
			// Destination port zero
			if (cnt == off_udp_dst + 11'd2 && dst_hi_zero && d1 == 8'h00) begin
				udp_ok <= 1'b0;
			end
			if (cnt == '0) begin
				udp_ok <= 1'b1;
			end
		end
	end

	// UDP length, header plus data
	always_ff @(posedge clk) begin
		d1_q <= d1;
		if (cnt == off_udp_len + 11'd2) begin
			udp_length <= {d1_q, d1};
		end
	end

endmodule

//--- src/crc32_check.sv
`timescale 1ns/1ps

module crc32_check
	import scan_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   frame_first,
	input  logic   in_data,
	input  octet_t d1,
	output logic   crc_ok
);

	// 0x04C11DB7 bit reversed, LSB first as on the wire
	localparam logic [31:0] crc_poly = 32'hedb88320;
	// Register value once the FCS itself has passed through
	localparam logic [31:0] crc_residue = 32'hdebb20e3;

	logic [31:0] crc_q;
	logic [31:0] crc_seed;

	function automatic logic [31:0] crc_octet(input logic [31:0] crc, input octet_t d);
		logic [31:0] c;
		int i;
		c = crc ^ {24'h0, d};
		for (i = 0; i < 8; i++) begin
			c = c[0] ? (c >> 1) ^ crc_poly : c >> 1;
		end
		return c;
	endfunction

	// Preset together with the first octet
	assign crc_seed = frame_first ? 32'hffffffff : crc_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			crc_q <= 32'hffffffff;
			crc_ok <= 1'b0;
		end else begin
			if (in_data || frame_first) begin
				crc_q <= crc_octet(crc_seed, d1);
			end
			crc_ok <= crc_q == crc_residue;
		end
	end

endmodule

//--- src/pkt_scanner.sv
`timescale 1ns/1ps

module pkt_scanner
	import scan_pkg::*;
#(
	parameter int max_frame_len = 1536,
	parameter int min_ifg = 10
) (
	input  logic         clk,
	input  logic         arst_n,
	input  rx_octet_t    rx,
	input  logic         enable_rx,
	output cfg_addr_t    cfg_addr,
	input  octet_t       cfg_data,
	output rx_octet_t    odata,
	output logic         status_valid,
	output scan_status_t status
);

	// Ethernet header plus FCS, and IPv4 header without options
	localparam logic [16:0] eth_overhead = 17'd18;
	localparam logic [16:0] ip_hdr_len = 17'd20;

	frame_cnt_t cnt;
	octet_t d1;
	logic in_data;
	logic frame_first;
	logic frame_end;
	logic mac_ok;
	logic ip_dst_ok;
	logic src_unicast;
	logic ip_hdr_ok;
	len16_t ip_length;
	logic udp_ok;
	len16_t udp_length;
	logic crc_ok;
	frame_cnt_t pack_len_q;
	logic ip_len_ok;
	logic udp_len_ok;
	logic ip_ok;
	scan_status_t status_now;
	scan_status_t status_q;

	rx_framer #(
		.max_frame_len(max_frame_len),
		.min_ifg(min_ifg)
	) rx_framer_i (
		.clk(clk),
		.arst_n(arst_n),
		.rx(rx),
		.enable_rx(enable_rx),
		.cnt(cnt),
		.d1(d1),
		.in_data(in_data),
		.frame_first(frame_first),
		.frame_end(frame_end),
		.odata(odata)
	);

	addr_match addr_match_i (
		.clk(clk),
		.arst_n(arst_n),
		.cnt(cnt),
		.d1(d1),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.mac_ok(mac_ok),
		.ip_dst_ok(ip_dst_ok),
		.src_unicast(src_unicast)
	);

	ip_hdr_check ip_hdr_check_i (
		.clk(clk),
		.arst_n(arst_n),
		.cnt(cnt),
		.d1(d1),
		.ip_hdr_ok(ip_hdr_ok),
		.ip_length(ip_length)
	);

	udp_hdr_check udp_hdr_check_i (
		.clk(clk),
		.arst_n(arst_n),
		.cnt(cnt),
		.d1(d1),
		.udp_ok(udp_ok),
		.udp_length(udp_length)
	);

	crc32_check crc32_check_i (
		.clk(clk),
		.arst_n(arst_n),
		.frame_first(frame_first),
		.in_data(in_data),
		.d1(d1),
		.crc_ok(crc_ok)
	);

	// Length and length checks follow the frame, frozen once data ends
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pack_len_q <= '0;
			ip_len_ok <= 1'b0;
			udp_len_ok <= 1'b0;
			status_q <= '0;
		end else begin
			if (in_data) begin
				pack_len_q <= cnt;
				ip_len_ok <= {6'b0, cnt} >= {1'b0, ip_length} + eth_overhead;
				udp_len_ok <= {1'b0, ip_length} >= {1'b0, udp_length} + ip_hdr_len;
			end
			if (frame_end) begin
				status_q <= status_now;
			end
		end
	end

	assign ip_ok = src_unicast & crc_ok & mac_ok & ip_hdr_ok & ip_dst_ok & ip_len_ok;

	always_comb begin
		status_now.category = (ip_ok && udp_ok && udp_len_ok) ? cat_udp : cat_other;
		status_now.crc_ok = crc_ok;
		status_now.mac_ok = mac_ok;
		status_now.ip_ok = ip_ok;
		status_now.pack_len = pack_len_q;
	end

	// Live word on the pulse, held copy afterwards
	assign status_valid = frame_end;
	assign status = frame_end ? status_now : status_q;

endmodule

//--- bench/pkt_scanner_chk.sv
`timescale 1ns/1ps

module pkt_scanner_chk (
	input logic clk,
	input logic arst_n,
	input logic status_valid,
	input logic odata_valid,
	input logic odata_last
);

	// Status is a single cycle strobe
	property status_one_cycle;
		@(posedge clk) disable iff (!arst_n) status_valid |=> !status_valid;
	endproperty

	// Last octet marker only on a valid octet
	property last_needs_valid;
		@(posedge clk) disable iff (!arst_n) odata_last |-> odata_valid;
	endproperty

	// Outputs stay quiet in reset
	property quiet_in_reset;
		@(posedge clk) !arst_n |-> (!status_valid && !odata_valid);
	endproperty

	assert property (status_one_cycle)
	else $error("status_valid stayed high for two cycles");

	assert property (last_needs_valid)
	else $error("odata.last seen without odata.valid");

	assert property (quiet_in_reset)
	else $error("status_valid or odata.valid high during reset");

endmodule

bind pkt_scanner pkt_scanner_chk pkt_scanner_chk_i (
	.clk(clk),
	.arst_n(arst_n),
	.status_valid(status_valid),
	.odata_valid(odata.valid),
	.odata_last(odata.last)
);

//--- bench/pkt_scanner_tb.sv
`timescale 1ns/1ps

module pkt_scanner_tb
	import scan_pkg::*;
();

	localparam int cycle_limit = 20000;
	localparam int watch_cycles = 20;

	logic clk;
	logic arst_n;
	rx_octet_t rx;
	logic enable_rx;
	cfg_addr_t cfg_addr;
	octet_t cfg_data;
	rx_octet_t odata;
	logic status_valid;
	scan_status_t status;

	octet_t cfg_mem[16];
	cfg_addr_t addr_q;
	octet_t frame_q[$];
	octet_t exp_q[$];
	octet_t got_q[$];
	int errors;
	int status_count;
	int odata_count;
	int last_count;
	int last_at;
	int cycles;
	scan_status_t last_status;

	// Fields of the next frame
	octet_t dst_mac[6];
	octet_t src_mac[6];
	octet_t dst_ip[4];
	octet_t ttl;
	logic [15:0] sport;
	logic [15:0] dport;
	int udp_len_adj;
	bit bad_cks;
	bit bad_fcs;
	bit bad_pre;
	int pay_len;

	pkt_scanner #(
		.max_frame_len(1536),
		.min_ifg(10)
	) pkt_scanner_i (
		.clk(clk),
		.arst_n(arst_n),
		.rx(rx),
		.enable_rx(enable_rx),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.odata(odata),
		.status_valid(status_valid),
		.status(status)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Config memory answers the previous cycle's address
	always begin
		@(negedge clk);
		addr_q = cfg_addr;
		@(posedge clk);
		#2;
		cfg_data = cfg_mem[addr_q];
	end

	// Collect output octets and status pulses mid cycle
	always @(negedge clk) begin
		if (odata.valid) begin
			got_q.push_back(odata.data);
			odata_count++;
		end
		// Position of the octet that carries the end marker
		if (odata.last) begin
			last_count++;
			last_at = got_q.size();
		end
		if (status_valid) begin
			status_count++;
			last_status = status;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run passed %0d clock cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Reflected CRC32, one bit at a time
	function automatic logic [31:0] crc_update(input logic [31:0] crc, input octet_t b);
		logic fb;
		int i;
		for (i = 0; i < 8; i++) begin
			fb = crc[0] ^ b[i];
			crc = crc >> 1;
			if (fb) begin
				crc = crc ^ 32'hedb88320;
			end
		end
		return crc;
	endfunction

	task automatic check_val(input string what, input int got, input int exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic set_defaults();
		dst_mac = '{8'h02, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01};
		src_mac = '{8'h02, 8'h11, 8'h22, 8'h33, 8'h44, 8'h55};
		dst_ip = '{8'd192, 8'd168, 8'd0, 8'd10};
		ttl = 8'd64;
		sport = 16'd5000;
		dport = 16'd4000;
		udp_len_adj = 0;
		bad_cks = 1'b0;
		bad_fcs = 1'b0;
		bad_pre = 1'b0;
		pay_len = 18 + int'($urandom % 40);
	endtask

	// Preamble, headers, payload and FCS, plus the expected output octets
	task automatic build_frame();
		octet_t hdr[20];
		logic [15:0] ip_len;
		logic [15:0] udp_len;
		logic [31:0] sum;
		logic [15:0] cks;
		logic [31:0] crc;
		int i;
		ip_len = 16'(28 + pay_len);
		udp_len = 16'(8 + pay_len + udp_len_adj);
		frame_q.delete();
		exp_q.delete();
		for (i = 0; i < 6; i++) exp_q.push_back(dst_mac[i]);
		for (i = 0; i < 6; i++) exp_q.push_back(src_mac[i]);
		exp_q.push_back(8'h08);
		exp_q.push_back(8'h00);
		hdr = '{8'h45, 8'h00, ip_len[15:8], ip_len[7:0], 8'h12, 8'h34, 8'h40, 8'h00,
			ttl, 8'h11, 8'h00, 8'h00, 8'd192, 8'd168, 8'd0, 8'd77,
			dst_ip[0], dst_ip[1], dst_ip[2], dst_ip[3]};
		// Header checksum with end around carry
		sum = 32'h0;
		for (i = 0; i < 20; i += 2) begin
			sum = sum + {16'h0, hdr[i], hdr[i + 1]};
		end
		sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
		sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
		cks = ~sum[15:0];
		if (bad_cks) cks = cks ^ 16'h0001;
		hdr[10] = cks[15:8];
		hdr[11] = cks[7:0];
		for (i = 0; i < 20; i++) exp_q.push_back(hdr[i]);
		exp_q.push_back(sport[15:8]);
		exp_q.push_back(sport[7:0]);
		exp_q.push_back(dport[15:8]);
		exp_q.push_back(dport[7:0]);
		exp_q.push_back(udp_len[15:8]);
		exp_q.push_back(udp_len[7:0]);
		exp_q.push_back(8'h00);
		exp_q.push_back(8'h00);
		for (i = 0; i < pay_len; i++) exp_q.push_back(8'($urandom));
		crc = 32'hffffffff;
		foreach (exp_q[i]) crc = crc_update(crc, exp_q[i]);
		crc = ~crc;
		// FCS goes out low octet first
		exp_q.push_back(crc[7:0]);
		exp_q.push_back(crc[15:8]);
		exp_q.push_back(crc[23:16]);
		exp_q.push_back(crc[31:24]);
		if (bad_fcs) exp_q[exp_q.size() - 1] = exp_q[exp_q.size() - 1] ^ 8'h01;
		for (i = 0; i < 7; i++) frame_q.push_back(8'h55);
		if (bad_pre) frame_q[3] = 8'h54;
		frame_q.push_back(8'hd5);
		foreach (exp_q[i]) frame_q.push_back(exp_q[i]);
	endtask

	task automatic send_frame(input int idle);
		repeat (idle) begin
			rx.valid = 1'b0;
			rx.data = 8'h00;
			@(posedge clk);
			#2;
		end
		got_q.delete();
		last_count = 0;
		last_at = 0;
		foreach (frame_q[i]) begin
			rx.valid = 1'b1;
			rx.data = frame_q[i];
			@(posedge clk);
			#2;
		end
		rx.valid = 1'b0;
		rx.data = 8'h00;
	endtask

	// Wait for the status pulse, then compare status and output octets
	task automatic expect_frame(input bit e_crc, input bit e_mac, input bit e_ip,
		input category_t e_cat);
		int start;
		int n;
		start = status_count;
		n = 0;
		while (status_count == start && n < 8) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (status_count == start) begin
			errors++;
			$display("Missing status: no status_valid within 8 cycles after rx.valid fell");
			return;
		end
		check_val("pack_len", int'(last_status.pack_len), exp_q.size());
		check_val("crc_ok", int'(last_status.crc_ok), int'(e_crc));
		check_val("mac_ok", int'(last_status.mac_ok), int'(e_mac));
		check_val("ip_ok", int'(last_status.ip_ok), int'(e_ip));
		check_val("category", int'(last_status.category), int'(e_cat));
		check_val("odata octet count", got_q.size(), exp_q.size());
		// End marker once, on the final FCS octet
		check_val("odata.last pulses", last_count, 1);
		check_val("odata.last position", last_at, exp_q.size());
		if (got_q.size() == exp_q.size()) begin
			foreach (exp_q[i]) check_val("odata octet", int'(got_q[i]), int'(exp_q[i]));
		end
	endtask

	task automatic expect_silence(input int s0, input int o0);
		repeat (watch_cycles) begin
			@(posedge clk);
			#2;
		end
		check_val("status_valid pulses of dropped frame", status_count - s0, 0);
		check_val("odata octets of dropped frame", odata_count - o0, 0);
	endtask

	task automatic test_good();
		set_defaults();
		build_frame();
		send_frame(12);
		expect_frame(1'b1, 1'b1, 1'b1, cat_udp);
	endtask

	task automatic test_bad_fcs();
		set_defaults();
		bad_fcs = 1'b1;
		build_frame();
		send_frame(12);
		expect_frame(1'b0, 1'b1, 1'b0, cat_other);
	endtask

	task automatic test_bad_addr();
		set_defaults();
		dst_mac[5] = 8'h02;
		build_frame();
		send_frame(12);
		expect_frame(1'b1, 1'b0, 1'b0, cat_other);
		set_defaults();
		dst_ip[3] = 8'd11;
		build_frame();
		send_frame(12);
		expect_frame(1'b1, 1'b1, 1'b0, cat_other);
	endtask

	task automatic test_bad_ip_hdr();
		set_defaults();
		bad_cks = 1'b1;
		build_frame();
		send_frame(12);
		expect_frame(1'b1, 1'b1, 1'b0, cat_other);
		set_defaults();
		ttl = 8'h00;
		build_frame();
		send_frame(12);
		expect_frame(1'b1, 1'b1, 1'b0, cat_other);
		// Group bit set in the source MAC
		set_defaults();
		src_mac[0] = 8'h03;
		build_frame();
		send_frame(12);
		expect_frame(1'b1, 1'b1, 1'b0, cat_other);
	endtask

	task automatic test_bad_udp();
		set_defaults();
		sport = 16'd80;
		build_frame();
		send_frame(12);
		expect_frame(1'b1, 1'b1, 1'b1, cat_other);
		set_defaults();
		dport = 16'd0;
		build_frame();
		send_frame(12);
		expect_frame(1'b1, 1'b1, 1'b1, cat_other);
		set_defaults();
		udp_len_adj = 1;
		build_frame();
		send_frame(12);
		expect_frame(1'b1, 1'b1, 1'b1, cat_other);
	endtask

	task automatic test_dropped();
		int s0;
		int o0;
		// Receiver disabled
		enable_rx = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		set_defaults();
		build_frame();
		s0 = status_count;
		o0 = odata_count;
		send_frame(12);
		expect_silence(s0, o0);
		enable_rx = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		set_defaults();
		bad_pre = 1'b1;
		build_frame();
		s0 = status_count;
		o0 = odata_count;
		send_frame(12);
		// Short gap right after the dropped burst
		set_defaults();
		build_frame();
		send_frame(6);
		expect_silence(s0, o0);
		// Oversized frame, octets ahead of the length cut still leave on odata
		set_defaults();
		pay_len = 1600 - 46;
		build_frame();
		s0 = status_count;
		send_frame(12);
		o0 = odata_count;
		expect_silence(s0, o0);
		test_good();
	endtask

	initial begin
		void'($urandom(12));
		errors = 0;
		status_count = 0;
		odata_count = 0;
		last_count = 0;
		last_at = 0;
		cycles = 0;
		arst_n = 1'b0;
		rx = '0;
		enable_rx = 1'b1;
		cfg_data = 8'h00;
		// Fill depends on the whole address, then the real entries
		for (int i = 0; i < 16; i++) cfg_mem[i] = 8'ha5 ^ 8'(i * 37);
		cfg_mem[0] = 8'h02;
		cfg_mem[1] = 8'h00;
		cfg_mem[2] = 8'h00;
		cfg_mem[3] = 8'h00;
		cfg_mem[4] = 8'h00;
		cfg_mem[5] = 8'h01;
		cfg_mem[6] = 8'd192;
		cfg_mem[7] = 8'd168;
		cfg_mem[8] = 8'd0;
		cfg_mem[9] = 8'd10;
		repeat (10) @(posedge clk);
		#2;
		arst_n = 1'b1;
		test_good();
		test_bad_fcs();
		test_bad_addr();
		test_bad_ip_hdr();
		test_bad_udp();
		test_dropped();
		$display("Checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- pkt_scanner.f
src/scan_pkg.sv
src/rx_framer.sv
src/addr_match.sv
src/ip_hdr_check.sv
src/udp_hdr_check.sv
src/crc32_check.sv
src/pkt_scanner.sv
bench/pkt_scanner_chk.sv
bench/pkt_scanner_tb.sv

//--- Makefile
# Verilator build and run for the packet scanner testbench

VERILATOR ?= verilator
TOP ?= pkt_scanner_tb
FLIST ?= pkt_scanner.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
